// File: verilog/ddr_test_pkg.sv
`default_nettype none

package ddr_test_pkg;

  // byte lanes of the local data bus
  localparam int lane_w    = 8;
  localparam int num_lanes = 2;
  localparam int data_w    = lane_w * num_lanes;

  // address fields
  typedef logic [1:0]  bank_t;
  typedef logic [12:0] row_t;
  typedef logic [9:0]  col_t;

  // one burst covers col_step columns
  localparam col_t col_step    = 10'd4;
  localparam int   burst_beats = 2;

  typedef logic [7:0] beat_count_t;

  localparam bank_t default_max_bank = 2'd3;
  localparam row_t  default_max_row  = 13'd3;
  localparam col_t  default_max_col  = 10'd16;

  // lane 0 sits in the low byte
  localparam logic [num_lanes-1:0][lane_w-1:0] lane_seeds = {8'd11, 8'd1};

endpackage

`default_nettype wire

// File: verilog/pattern_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pattern_if;

  // stream control
  logic advance;
  logic capture;
  logic reload;

  // current word of the pseudo-random stream
  logic [ddr_test_pkg::data_w-1:0] data;

  modport gen (input advance, input capture, input reload, output data);

  modport ctrl (output advance, output capture, output reload);

  modport check (input data);

endinterface

`default_nettype wire

// File: verilog/lfsr_lane.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_lane #(
  parameter logic [ddr_test_pkg::lane_w-1:0] seed = ddr_test_pkg::lane_seeds[0]
) (
  input  wire                              clk,
  input  wire                              reset_n,
  input  wire                              advance,
  input  wire                              load,
  input  wire  [ddr_test_pkg::lane_w-1:0]  load_value,
  output logic [ddr_test_pkg::lane_w-1:0]  value
);

  logic feedback;

  // taps 7, 5, 4 and 3
  assign feedback = value[7] ^ value[5] ^ value[4] ^ value[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      value <= seed;
    end
    else if (load)
    begin
      // load wins over advance
      value <= load_value;
    end
    else if (advance)
    begin
      value <= {value[ddr_test_pkg::lane_w-2:0], feedback};
    end
  end

endmodule

`default_nettype wire

// File: verilog/pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_gen (
  input  wire     clk,
  input  wire     reset_n,
  pattern_if.gen  pat
);

  localparam int lane_w = ddr_test_pkg::lane_w;

  logic [ddr_test_pkg::data_w-1:0] seed_store;
  logic [ddr_test_pkg::data_w-1:0] word;

  // ---------------------------------------------------------------------------
  // reload store
  // ---------------------------------------------------------------------------

  // word seen at the first write of a pass, replayed for the read phase
  always_ff @(posedge clk)
  begin
    if (pat.capture)
    begin
      seed_store <= word;
    end
  end

  // ---------------------------------------------------------------------------
  // one generator per byte lane
  // ---------------------------------------------------------------------------

  for (genvar i = 0; i < ddr_test_pkg::num_lanes; i++)
  begin : g_lane
    lfsr_lane #(
      .seed (ddr_test_pkg::lane_seeds[i])
    ) lfsr_lane_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .advance    (pat.advance),
      .load       (pat.reload),
      .load_value (seed_store[i*lane_w +: lane_w]),
      .value      (word[i*lane_w +: lane_w])
    );
  end

  assign pat.data = word;

endmodule

`default_nettype wire

// File: verilog/addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module addr_counter #(
  parameter ddr_test_pkg::bank_t max_bank = ddr_test_pkg::default_max_bank,
  parameter ddr_test_pkg::row_t  max_row  = ddr_test_pkg::default_max_row,
  parameter ddr_test_pkg::col_t  max_col  = ddr_test_pkg::default_max_col
) (
  input  wire                  clk,
  input  wire                  reset_n,
  input  wire                  step,
  input  wire                  clear,
  output ddr_test_pkg::bank_t  bank_addr,
  output ddr_test_pkg::row_t   row_addr,
  output ddr_test_pkg::col_t   col_addr,
  output logic                 at_last
);

  // column first, then row, then bank
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      bank_addr <= '0;
      row_addr  <= '0;
      col_addr  <= '0;
    end
    else if (clear)
    begin
      bank_addr <= '0;
      row_addr  <= '0;
      col_addr  <= '0;
    end
    else if (step)
    begin
      if (col_addr >= max_col)
      begin
        col_addr <= '0;
        if (row_addr == max_row)
        begin
          row_addr  <= '0;
          bank_addr <= (bank_addr == max_bank) ? '0 : bank_addr + ddr_test_pkg::bank_t'(1);
        end
        else
        begin
          row_addr <= row_addr + ddr_test_pkg::row_t'(1);
        end
      end
      else
      begin
        col_addr <= col_addr + ddr_test_pkg::col_step;
      end
    end
  end

  assign at_last = (bank_addr == max_bank) && (row_addr == max_row) && (col_addr == max_col);

  // a column that steps past max_col would never raise at_last
  assert property (@(posedge clk) disable iff (!reset_n)
    col_addr <= max_col);

endmodule

`default_nettype wire

// File: verilog/test_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module test_sequencer (
  input  wire      clk,
  input  wire      reset_n,
  input  wire      local_ready,
  input  wire      local_rdata_valid,
  output logic     write_req,
  output logic     read_req,
  output logic     burstbegin,
  output logic     test_active,
  output logic     test_complete,
  output logic     step,
  output logic     clear,
  input  wire      at_last,
  pattern_if.ctrl  pat
);

  localparam ddr_test_pkg::beat_count_t burst_inc =
    ddr_test_pkg::beat_count_t'(ddr_test_pkg::burst_beats);
  localparam ddr_test_pkg::beat_count_t one_beat = ddr_test_pkg::beat_count_t'(1);

  typedef enum logic [2:0] {
    s_idle,
    s_wr_first,
    s_wr_second,
    s_wr_last,
    s_rd_issue,
    s_drain
  } state_t;

  state_t                     state;
  ddr_test_pkg::beat_count_t  outstanding;
  logic                       capture_q;
  logic                       reload_q;
  logic                       burst_accept;
  logic                       rd_accept;

  // burstbegin is high on every read request, on the first write beat only
  assign burst_accept = burstbegin & local_ready & (write_req | read_req);
  assign rd_accept    = read_req & local_ready;

  assign step  = burst_accept & ~at_last;
  assign clear = burst_accept & at_last;

  // stream moves on accepted write beats and returned read beats
  assign pat.advance = (write_req & local_ready) | local_rdata_valid;
  assign pat.capture = capture_q;
  assign pat.reload  = reload_q;

  // ---------------------------------------------------------------------------
  // outstanding read beats
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      outstanding <= '0;
    end
    else
    begin
      case ({rd_accept, local_rdata_valid})
        2'b10:   outstanding <= outstanding + burst_inc;
        2'b11:   outstanding <= outstanding + burst_inc - one_beat;
        2'b01:   outstanding <= outstanding - one_beat;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // pass FSM
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= s_idle;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burstbegin    <= 1'b0;
      test_active   <= 1'b0;
      test_complete <= 1'b0;
      capture_q     <= 1'b0;
      reload_q      <= 1'b0;
    end
    else
    begin
      capture_q     <= 1'b0;
      reload_q      <= 1'b0;
      test_complete <= 1'b0;
      case (state)
        s_idle:
        begin
          write_req   <= 1'b1;
          burstbegin  <= 1'b1;
          test_active <= 1'b1;
          capture_q   <= 1'b1;
          state       <= s_wr_first;
        end
        s_wr_first:
        begin
          if (local_ready)
          begin
            burstbegin <= 1'b0;
            state      <= at_last ? s_wr_last : s_wr_second;
          end
        end
        s_wr_second:
        begin
          if (local_ready)
          begin
            burstbegin <= 1'b1;
            state      <= s_wr_first;
          end
        end
        s_wr_last:
        begin
          // second beat of the final burst, then replay for reads
          if (local_ready)
          begin
            write_req  <= 1'b0;
            read_req   <= 1'b1;
            burstbegin <= 1'b1;
            reload_q   <= 1'b1;
            state      <= s_rd_issue;
          end
        end
        s_rd_issue:
        begin
          if (local_ready && at_last)
          begin
            read_req   <= 1'b0;
            burstbegin <= 1'b0;
            state      <= s_drain;
          end
        end
        s_drain:
        begin
          if (outstanding == '0)
          begin
            test_complete <= 1'b1;
            test_active   <= 1'b0;
            state         <= s_idle;
          end
        end
        default:
        begin
          state <= s_idle;
        end
      endcase
    end
  end

  // returned beat always has a request behind it
  assert property (@(posedge clk) disable iff (!reset_n)
    local_rdata_valid |-> outstanding != '0);

  assert property (@(posedge clk) disable iff (!reset_n)
    !(read_req && write_req));

endmodule

`default_nettype wire

// File: verilog/read_checker.sv
`timescale 1ns/1ps
`default_nettype none

module read_checker (
  input  wire                                  clk,
  input  wire                                  reset_n,
  input  wire  [ddr_test_pkg::data_w-1:0]      local_rdata,
  input  wire                                  local_rdata_valid,
  pattern_if.check                             pat,
  output logic [ddr_test_pkg::num_lanes-1:0]   pnf_per_byte,
  output logic                                 pnf_persist
);

  localparam int lane_w    = ddr_test_pkg::lane_w;
  localparam int num_lanes = ddr_test_pkg::num_lanes;

  logic [num_lanes-1:0] compare;
  logic [num_lanes-1:0] compare_reg;
  logic [num_lanes-1:0] lane_pass;
  logic                 valid_d1;
  logic                 seen_valid;
  logic                 seen_d1;
  logic                 seen_d2;
  logic                 persist_int;

  // expected word is the stream value in the valid cycle
  always_comb
  begin
    for (int i = 0; i < num_lanes; i++)
    begin
      compare[i] = pat.data[i*lane_w +: lane_w] == local_rdata[i*lane_w +: lane_w];
    end
  end

  // ---------------------------------------------------------------------------
  // three register stages for compare, flag and output
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg  <= '1;
      valid_d1     <= 1'b0;
      lane_pass    <= '1;
      pnf_per_byte <= '1;
      seen_valid   <= 1'b0;
      seen_d1      <= 1'b0;
      seen_d2      <= 1'b0;
      persist_int  <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      compare_reg <= compare;
      valid_d1    <= local_rdata_valid;
      if (valid_d1)
      begin
        lane_pass <= compare_reg;
      end
      pnf_per_byte <= lane_pass;

      seen_valid <= seen_valid | local_rdata_valid;
      seen_d1    <= seen_valid;
      seen_d2    <= seen_d1;
      // first result sets it, later results can only clear it
      persist_int <= (&lane_pass) & seen_d1 & (persist_int | ~seen_d2);
      pnf_persist <= persist_int;
    end
  end

  assert property (@(posedge clk) disable iff (!reset_n)
    local_rdata_valid |-> !$isunknown(local_rdata));

endmodule

`default_nettype wire

// File: verilog/ddr_test_driver.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_test_driver #(
  parameter ddr_test_pkg::bank_t max_bank = ddr_test_pkg::default_max_bank,
  parameter ddr_test_pkg::row_t  max_row  = ddr_test_pkg::default_max_row,
  parameter ddr_test_pkg::col_t  max_col  = ddr_test_pkg::default_max_col
) (
  input  wire                                  clk,
  input  wire                                  reset_n,
  input  wire                                  local_ready,
  input  wire                                  local_rdata_valid,
  input  wire  [ddr_test_pkg::data_w-1:0]      local_rdata,
  output logic                                 local_write_req,
  output logic                                 local_read_req,
  output logic                                 local_burstbegin,
  output ddr_test_pkg::bank_t                  local_bank_addr,
  output ddr_test_pkg::row_t                   local_row_addr,
  output ddr_test_pkg::col_t                   local_col_addr,
  output logic [ddr_test_pkg::data_w-1:0]      local_wdata,
  output logic [ddr_test_pkg::num_lanes-1:0]   pnf_per_byte,
  output logic                                 pnf_persist,
  output logic                                 test_active,
  output logic                                 test_complete
);

  logic step;
  logic clear;
  logic at_last;

  pattern_if pat ();

  test_sequencer test_sequencer_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burstbegin        (local_burstbegin),
    .test_active       (test_active),
    .test_complete     (test_complete),
    .step              (step),
    .clear             (clear),
    .at_last           (at_last),
    .pat               (pat)
  );

  addr_counter #(
    .max_bank (max_bank),
    .max_row  (max_row),
    .max_col  (max_col)
  ) addr_counter_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .step      (step),
    .clear     (clear),
    .bank_addr (local_bank_addr),
    .row_addr  (local_row_addr),
    .col_addr  (local_col_addr),
    .at_last   (at_last)
  );

  pattern_gen pattern_gen_i (
    .clk     (clk),
    .reset_n (reset_n),
    .pat     (pat)
  );

  read_checker read_checker_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .pat               (pat),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

  // write data comes straight off the stream
  assign local_wdata = pat.data;

endmodule

`default_nettype wire

// File: bench/ddr_test_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_test_monitor #(
  parameter int max_bank     = 3,
  parameter int max_row      = 3,
  parameter int max_col      = 16,
  parameter int num_passes   = 4,
  parameter int corrupt_pass = 2
) (
  input  wire                                clk,
  input  wire                                reset_n,
  input  wire                                local_ready,
  input  wire                                local_rdata_valid,
  input  wire  [ddr_test_pkg::data_w-1:0]    local_rdata,
  input  wire                                local_write_req,
  input  wire                                local_read_req,
  input  wire                                local_burstbegin,
  input  wire  [1:0]                         local_bank_addr,
  input  wire  [12:0]                        local_row_addr,
  input  wire  [9:0]                         local_col_addr,
  input  wire  [ddr_test_pkg::data_w-1:0]    local_wdata,
  input  wire  [ddr_test_pkg::num_lanes-1:0] pnf_per_byte,
  input  wire                                pnf_persist,
  input  wire                                test_active,
  input  wire                                test_complete,
  output logic                               done,
  output int                                 error_count,
  output int                                 check_count
);

  localparam int bursts = (max_bank + 1) * (max_row + 1) * (max_col / 4 + 1);
  localparam logic [15:0] seed_word = {8'd11, 8'd1};

  logic [15:0] model_word;
  logic [15:0] exp_q[$];
  int          exp_bank;
  int          exp_row;
  int          exp_col;
  int          wr_beat;
  int          wr_beats;
  int          wr_bursts;
  int          rd_bursts;
  int          rd_beats;
  int          pass_idx;
  int          cyc;
  int          fail_age;
  logic        fail_seen;
  logic        seen_read;
  logic        rose;
  logic        prev_complete;
  logic        pv[3];
  logic [1:0]  pl[3];

  function automatic logic [7:0] lfsr_next(input logic [7:0] v);
    return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report(input string msg);
    error_count++;
    $display("error: %s", msg);
  endtask

  // column steps by 4 and carries into row and bank
  task automatic step_addr();
    if (exp_col >= max_col)
    begin
      exp_col = 0;
      if (exp_row == max_row)
      begin
        exp_row  = 0;
        exp_bank = (exp_bank == max_bank) ? 0 : exp_bank + 1;
      end
      else
      begin
        exp_row++;
      end
    end
    else
    begin
      exp_col += 4;
    end
  endtask

  task automatic check_addr();
    check_value("local_bank_addr", 32'(local_bank_addr), 32'(exp_bank));
    check_value("local_row_addr", 32'(local_row_addr), 32'(exp_row));
    check_value("local_col_addr", 32'(local_col_addr), 32'(exp_col));
    step_addr();
  endtask

  // --------------------------------------------------------------------------
  // per-cycle checks sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge clk)
  begin
    logic [15:0] exp_word;
    logic [1:0]  lanes;
    if (!reset_n)
    begin
      model_word = seed_word;
      exp_q.delete();
      {exp_bank, exp_row, exp_col} = '0;
      {wr_beat, wr_beats, wr_bursts, rd_bursts, rd_beats, cyc, fail_age} = '0;
      {fail_seen, seen_read, rose, prev_complete} = '0;
      pv = '{3{1'b0}};
    end
    else
    begin
      if (cyc == 0)
      begin
        check_value("local_write_req", 32'(local_write_req), 0);
        check_value("local_read_req", 32'(local_read_req), 0);
        check_value("local_burstbegin", 32'(local_burstbegin), 0);
        check_value("test_active", 32'(test_active), 0);
        check_value("test_complete", 32'(test_complete), 0);
        check_value("pnf_per_byte", 32'(pnf_per_byte), 32'h3);
        check_value("pnf_persist", 32'(pnf_persist), 0);
      end
      if (cyc == 1)
        check_value("local_write_req", 32'(local_write_req), 1);

      // result of a read beat shows up 3 cycles later
      if (pv[2])
        check_value("pnf_per_byte", 32'(pnf_per_byte), 32'(pl[2]));
      pv[2] = pv[1];
      pl[2] = pl[1];
      pv[1] = pv[0];
      pl[1] = pl[0];
      pv[0] = 1'b0;

      if (pnf_persist && !seen_read)
        report("pnf_persist high before any read data");
      if (pnf_persist)
        rose = 1'b1;
      if (rose && !fail_seen && !pnf_persist)
        report("pnf_persist fell without a failed beat");
      if (fail_seen && fail_age >= 5 && pnf_persist)
        report("pnf_persist high after a failed beat");

      if (local_write_req && local_read_req)
        report("write and read requests high together");

      if (local_write_req && local_ready)
      begin
        check_value("local_wdata", 32'(local_wdata), 32'(model_word));
        check_value("local_burstbegin", 32'(local_burstbegin), 32'(wr_beat == 0));
        check_value("test_active", 32'(test_active), 1);
        exp_q.push_back(model_word);
        model_word = {lfsr_next(model_word[15:8]), lfsr_next(model_word[7:0])};
        if (wr_beat == 0)
        begin
          check_addr();
          wr_bursts++;
        end
        wr_beat ^= 1;
        wr_beats++;
      end

      if (local_read_req && local_ready)
      begin
        check_value("local_burstbegin", 32'(local_burstbegin), 1);
        check_addr();
        rd_bursts++;
      end

      if (local_rdata_valid)
      begin
        seen_read = 1'b1;
        rd_beats++;
        if (exp_q.size() == 0)
        begin
          report("read beat returned with no write data to compare");
          exp_word = '0;
        end
        else
        begin
          exp_word = exp_q.pop_front();
        end
        lanes[0] = local_rdata[7:0] == exp_word[7:0];
        lanes[1] = local_rdata[15:8] == exp_word[15:8];
        pv[0] = 1'b1;
        pl[0] = lanes;
        if (lanes != 2'b11 && !fail_seen)
        begin
          fail_seen = 1'b1;
          fail_age  = 0;
        end
      end

      if (test_complete)
      begin
        if (prev_complete)
          report("test_complete high for more than one cycle");
        check_value("write beats", 32'(wr_beats), 32'(2 * bursts));
        check_value("read beats", 32'(rd_beats), 32'(2 * bursts));
        check_value("write bursts", 32'(wr_bursts), 32'(bursts));
        check_value("read bursts", 32'(rd_bursts), 32'(bursts));
        // passes before the corrupted one end clean, the rest stay failed
        check_value("pnf_persist", 32'(pnf_persist), 32'(pass_idx < corrupt_pass));
        {wr_beat, wr_beats, wr_bursts, rd_bursts, rd_beats} = '0;
        pass_idx++;
      end
      prev_complete = test_complete;
      if (fail_seen)
        fail_age++;
      cyc++;
    end
  end

  // --------------------------------------------------------------------------
  // pass sequencing with a bounded wait per pass
  // --------------------------------------------------------------------------

  initial
  begin
    int waited;
    done        = 1'b0;
    error_count = 0;
    check_count = 0;
    pass_idx    = 0;
    waited      = 0;
    while (!reset_n && waited < 100)
    begin
      @(negedge clk);
      waited++;
    end
    if (!reset_n)
      report("timeout waiting for reset release");
    for (int p = 0; p < num_passes; p++)
    begin
      waited = 0;
      while (pass_idx <= p && waited < 5000)
      begin
        @(negedge clk);
        waited++;
      end
      if (pass_idx <= p)
      begin
        $display("error: timeout waiting for the end of pass %0d", p + 1);
        error_count++;
        break;
      end
    end
    done = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_ddr_test_driver.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_test_driver;

  localparam int max_bank     = 3;
  localparam int max_row      = 3;
  localparam int max_col      = 16;
  localparam int corrupt_pass = 2;

  logic        clk;
  logic        reset_n;
  logic        local_ready;
  logic        local_rdata_valid;
  logic [15:0] local_rdata;
  logic        local_write_req;
  logic        local_read_req;
  logic        local_burstbegin;
  logic [1:0]  local_bank_addr;
  logic [12:0] local_row_addr;
  logic [9:0]  local_col_addr;
  logic [15:0] local_wdata;
  logic [1:0]  pnf_per_byte;
  logic        pnf_persist;
  logic        test_active;
  logic        test_complete;
  logic        done;
  int          error_count;
  int          check_count;

  // memory model keyed by {bank, row, col, beat}
  logic [15:0] mem [logic [25:0]];
  logic [15:0] rsp_data[$];
  int          rsp_cycle[$];
  logic [24:0] wr_base;
  int          cycle;
  int          last_rsp;
  int          passes_done;
  int          rd_beat_in_pass;
  int          model_errors;

  ddr_test_driver #(
    .max_bank (2'(max_bank)),
    .max_row  (13'(max_row)),
    .max_col  (10'(max_col))
  ) ddr_test_driver_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .local_bank_addr   (local_bank_addr),
    .local_row_addr    (local_row_addr),
    .local_col_addr    (local_col_addr),
    .local_wdata       (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_active       (test_active),
    .test_complete     (test_complete)
  );

  ddr_test_monitor #(
    .max_bank     (max_bank),
    .max_row      (max_row),
    .max_col      (max_col),
    .corrupt_pass (corrupt_pass)
  ) ddr_test_monitor_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycle = cycle + 1;

  // --------------------------------------------------------------------------
  // memory side sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge clk)
  begin
    logic [25:0] key;
    int          t0;
    if (reset_n && local_write_req && local_ready)
    begin
      if (local_burstbegin)
        wr_base = {local_bank_addr, local_row_addr, local_col_addr};
      key      = {wr_base, !local_burstbegin};
      mem[key] = local_wdata;
    end
    if (reset_n && local_read_req && local_ready)
    begin
      t0 = cycle + int'($urandom_range(1, 8));
      if (t0 <= last_rsp)
        t0 = last_rsp + 1;
      for (int b = 0; b < 2; b++)
      begin
        key = {local_bank_addr, local_row_addr, local_col_addr, b[0]};
        if (!mem.exists(key))
        begin
          model_errors++;
          $display("error: read of an address that was never written");
          rsp_data.push_back(16'h0);
        end
        else
        begin
          rsp_data.push_back(mem[key]);
        end
        rsp_cycle.push_back(t0 + b);
      end
      last_rsp = t0 + 1;
    end
    if (reset_n && test_complete)
    begin
      passes_done++;
      rd_beat_in_pass = 0;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus driven 1 ns after the rising edge
  // --------------------------------------------------------------------------

  initial
  begin
    void'($urandom(96));
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata_valid = 1'b0;
    local_rdata       = '0;
    cycle             = 0;
    last_rsp          = 0;
    passes_done       = 0;
    rd_beat_in_pass   = 0;
    model_errors      = 0;
    repeat (8) @(posedge clk);
    #1 reset_n = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      local_ready       = $urandom_range(0, 3) != 0;
      local_rdata_valid = 1'b0;
      if (rsp_cycle.size() != 0 && rsp_cycle[0] <= cycle)
      begin
        local_rdata_valid = 1'b1;
        local_rdata       = rsp_data.pop_front();
        void'(rsp_cycle.pop_front());
        // third pass gets one bad byte in lane 1
        if (passes_done == corrupt_pass && rd_beat_in_pass == 37)
          local_rdata = local_rdata ^ 16'h5a00;
        rd_beat_in_pass++;
      end
    end
  end

  initial
  begin
    int waited;
    waited = 0;
    while (done !== 1'b1 && waited < 30000)
    begin
      @(posedge clk);
      waited++;
    end
    if (done !== 1'b1)
      $display("error: timeout waiting for the monitor to finish");
    $display("checks=%0d errors=%0d model_errors=%0d", check_count, error_count, model_errors);
    if (done === 1'b1 && error_count == 0 && model_errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ddr_test_driver.f
verilog/ddr_test_pkg.sv
verilog/pattern_if.sv
verilog/lfsr_lane.sv
verilog/pattern_gen.sv
verilog/addr_counter.sv
verilog/test_sequencer.sv
verilog/read_checker.sv
verilog/ddr_test_driver.sv
bench/ddr_test_monitor.sv
bench/tb_ddr_test_driver.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ddr_test_driver.f --top-module tb_ddr_test_driver
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_ddr_test_driver)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1
